//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_whack
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM     = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# a crashed simulator counts as a failed run
run: $(SIM)
	$(SIM) > $(LOG) 2>&1 || echo '** FAIL **' >> $(LOG)
	@cat $(LOG)
	@if grep -q -F '** FAIL **' $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_whack.sv
`timescale 1ns/1ps

module tb_whack;

        localparam int tick_div = 40;
        localparam int scan_div = 2;

        localparam logic [2:0] k_check = 3'd0;
        localparam logic [2:0] k_start = 3'd1;
        localparam logic [2:0] k_byte  = 3'd2;
        localparam logic [2:0] k_wait  = 3'd3;  // arg counts ticks
        localparam logic [2:0] k_rand  = 3'd4;  // arg counts random presses

        typedef struct packed {
                logic [2:0]  kind;
                logic [7:0]  arg;
                logic        model;  // expected values from the reference model
                logic [15:0] led;
                logic [15:0] nums;
        } step_t;

        localparam int n_steps = 38;
        localparam step_t steps [n_steps] = '{
                '{k_check, 8'h00, 1'b0, 16'h0000, 16'hffff},
                '{k_start, 8'h00, 1'b0, 16'hff01, 16'h3010},
                '{k_byte,  8'h16, 1'b0, 16'hff01, 16'h0110},
                '{k_byte,  8'hf0, 1'b0, 16'hff01, 16'h0110},
                '{k_byte,  8'h16, 1'b0, 16'hff01, 16'h0110},
                '{k_byte,  8'h1e, 1'b0, 16'hff01, 16'h1210},
                '{k_byte,  8'h1e, 1'b0, 16'hff01, 16'h1210},  // typematic repeat
                '{k_byte,  8'h29, 1'b0, 16'h80ff, 16'h1210},
                '{k_byte,  8'h7d, 1'b0, 16'h80ff, 16'h1209},
                '{k_byte,  8'hf0, 1'b0, 16'h80ff, 16'h1209},
                '{k_byte,  8'h7d, 1'b0, 16'h80ff, 16'h1209},
                '{k_byte,  8'h7d, 1'b0, 16'h80ff, 16'h1299},
                '{k_byte,  8'he0, 1'b0, 16'h80ff, 16'h1299},
                '{k_byte,  8'h69, 1'b0, 16'h80ff, 16'h1291},
                '{k_byte,  8'h1c, 1'b0, 16'h80ff, 16'h1291},  // letter key
                '{k_start, 8'h00, 1'b1, 16'h0000, 16'h0000},
                '{k_wait,  8'd1,  1'b1, 16'h0000, 16'h0000},
                '{k_wait,  8'd5,  1'b1, 16'h0000, 16'h0000},
                '{k_wait,  8'd6,  1'b1, 16'h0000, 16'h0000},  // time runs out
                '{k_wait,  8'd2,  1'b1, 16'h0000, 16'h0000},
                '{k_start, 8'h00, 1'b0, 16'h0000, 16'hffff},
                '{k_start, 8'h00, 1'b0, 16'hff01, 16'h3010},
                '{k_byte,  8'h36, 1'b0, 16'hff01, 16'h0610},
                '{k_byte,  8'h45, 1'b0, 16'hff01, 16'h6010},
                '{k_byte,  8'h29, 1'b0, 16'h80ff, 16'h6010},
                '{k_byte,  8'h46, 1'b0, 16'h80ff, 16'h6009},
                '{k_byte,  8'h7d, 1'b0, 16'h80ff, 16'h6099},
                '{k_start, 8'h00, 1'b1, 16'h0000, 16'h0000},
                '{k_rand,  8'd40, 1'b1, 16'h0000, 16'h0000},
                '{k_wait,  8'd20, 1'b1, 16'h0000, 16'h0000},
                '{k_start, 8'h00, 1'b0, 16'h0000, 16'hffff},
                '{k_start, 8'h00, 1'b0, 16'hff01, 16'h3010},
                '{k_byte,  8'h29, 1'b0, 16'h80ff, 16'h3010},
                '{k_byte,  8'h45, 1'b0, 16'h80ff, 16'h3000},
                '{k_byte,  8'h1e, 1'b0, 16'h80ff, 16'h3002},
                '{k_start, 8'h00, 1'b1, 16'h0000, 16'h0000},
                '{k_rand,  8'd12, 1'b1, 16'h0000, 16'h0000},  // goal of two hits
                '{k_start, 8'h00, 1'b0, 16'h0000, 16'hffff}
        };

        localparam logic [7:0] main_row [10] = '{
                8'h45, 8'h16, 8'h1e, 8'h26, 8'h25, 8'h2e, 8'h36, 8'h3d, 8'h3e, 8'h46
        };

        logic        clk = 1'b0;
        logic        out_rst;
        logic [7:0]  scan_code;
        logic        scan_valid;
        logic        start;
        logic [15:0] led;
        logic [3:0]  digit;
        logic [6:0]  display;

        int          cyc = 0;     // rising edges seen by the stimulus process
        int          errors = 0;
        int          checks = 0;
        int          cur_step = 0;
        int          play_cyc;
        int          m_remain;
        int          m_score;
        int          m_goal;
        int          m_ticks;
        logic        m_play = 1'b0;
        logic        m_over = 1'b0;
        logic [15:0] m_lfsr;
        logic [15:0] rnd = 16'd7639;

        whack_top #(.TICK_DIV(tick_div), .SCAN_DIV(scan_div)) whack_top_inst (
                .clk        (clk),
                .out_rst    (out_rst),
                .scan_code  (scan_code),
                .scan_valid (scan_valid),
                .start      (start),
                .led        (led),
                .digit      (digit),
                .display    (display)
        );

        always #2 clk = ~clk;

        function automatic logic [15:0] galois_step(input logic [15:0] v, input logic [15:0] taps);
                logic [15:0] n;
                n = {1'b0, v[15:1]};
                if (v[0])
                        n = n ^ taps;
                return n;
        endfunction

        // four bits per key and one step per bit
        function automatic int rand_digit();
                int v;
                v = 0;
                for (int b = 0; b < 4; b++) begin
                        v = (v << 1) | int'(rnd[0]);
                        rnd = galois_step(rnd, 16'hd008);
                end
                return v % 10;
        endfunction

        function automatic logic [7:0] to_bcd(input int v);
                return {4'(v / 10), 4'(v % 10)};
        endfunction

        function automatic int bcd_value(input logic [7:0] b);
                return int'(b[7:4]) * 10 + int'(b[3:0]);
        endfunction

        function automatic logic [3:0] seg_value(input logic [6:0] s);
                case (s)
                7'h40:   return 4'd0;
                7'h79:   return 4'd1;
                7'h24:   return 4'd2;
                7'h30:   return 4'd3;
                7'h19:   return 4'd4;
                7'h12:   return 4'd5;
                7'h02:   return 4'd6;
                7'h78:   return 4'd7;
                7'h00:   return 4'd8;
                7'h10:   return 4'd9;
                7'h7f:   return 4'hf;  // blank
                default: return 4'he;
                endcase
        endfunction

        function automatic void catch_up_ticks();
                while (m_play && play_cyc + tick_div * (m_ticks + 1) <= cyc) begin
                        m_ticks++;
                        m_remain--;
                        m_lfsr = galois_step(m_lfsr, 16'hb400);
                        if (m_remain == 0) begin
                                m_play = 1'b0;
                                m_over = 1'b1;
                        end
                end
        endfunction

        function automatic logic [15:0] expect_led();
                return m_over ? 16'hffff : m_lfsr;
        endfunction

        function automatic logic [15:0] expect_nums();
                return {to_bcd(m_remain), to_bcd(m_score)};
        endfunction

        task automatic next_edge(input int n);
                repeat (n) begin
                        @(posedge clk);
                        cyc++;
                end
        endtask

        // called right after a rising edge
        task automatic send_byte(input logic [7:0] b);
                scan_code  <= b;
                scan_valid <= 1'b1;
                next_edge(1);
                scan_valid <= 1'b0;
        endtask

        task automatic pulse_start();
                start <= 1'b1;
                next_edge(2);
                start <= 1'b0;
        endtask

        task automatic goto_tick(input int n);
                int target;
                target = play_cyc + tick_div * ((cyc - play_cyc) / tick_div + n);
                next_edge(target - cyc);
        endtask

        // last value seen on each anode over eight scan slots wins
        task automatic read_display(output logic [15:0] shown);
                shown = 16'heeee;
                repeat (8 * scan_div + 2) begin
                        next_edge(1);
                        @(negedge clk);
                        case (digit)
                        4'b0111: shown[15:12] = seg_value(display);
                        4'b1011: shown[11:8]  = seg_value(display);
                        4'b1101: shown[7:4]   = seg_value(display);
                        4'b1110: shown[3:0]   = seg_value(display);
                        default: ;
                        endcase
                end
        endtask

        task automatic check_outputs(input logic [15:0] exp_led, input logic [15:0] exp_nums);
                logic [15:0] shown;
                read_display(shown);
                checks++;
                assert (led == exp_led) else begin
                        errors++;
                        $display("error: led expected %h, got %h at step %0d",
                                 exp_led, led, cur_step);
                end
                assert (shown == exp_nums) else begin
                        errors++;
                        $display("error: display expected %h, got %h at step %0d",
                                 exp_nums, shown, cur_step);
                end
        endtask

        task automatic press_random();
                logic [3:0] k;
                k = 4'(rand_digit());
                goto_tick(1);  // press lands just after a new pattern
                catch_up_ticks();
                if (m_play && m_lfsr[k]) begin
                        m_score++;
                        if (m_score == m_goal) begin
                                m_play = 1'b0;
                                m_over = 1'b1;
                        end
                end
                send_byte(main_row[k]);
                send_byte(8'hf0);
                send_byte(main_row[k]);
                check_outputs(expect_led(), expect_nums());
        endtask

        initial begin
                out_rst    <= 1'b1;
                scan_code  <= 8'h00;
                scan_valid <= 1'b0;
                start      <= 1'b0;
                next_edge(3);
                out_rst <= 1'b0;
                for (int i = 0; i < n_steps; i++) begin
                        cur_step = i;
                        case (steps[i].kind)
                        k_start: begin
                                next_edge(1);
                                pulse_start();
                                if (steps[i].model) begin
                                        play_cyc = cyc;  // new state and led land here
                                        m_play   = 1'b1;
                                        m_over   = 1'b0;
                                        m_ticks  = 0;
                                        m_score  = 0;
                                        m_lfsr   = 16'hace1;
                                        m_remain = bcd_value(steps[i-1].nums[15:8]);
                                        m_goal   = bcd_value(steps[i-1].nums[7:0]);
                                end
                        end
                        k_byte: begin
                                next_edge(1);
                                send_byte(steps[i].arg);
                                next_edge(1);
                        end
                        k_wait: begin
                                goto_tick(int'(steps[i].arg));
                                catch_up_ticks();
                        end
                        k_rand: begin
                                for (int p = 0; p < int'(steps[i].arg); p++)
                                        press_random();
                        end
                        default: ;
                        endcase
                        if (steps[i].kind != k_rand) begin
                                if (steps[i].model)
                                        check_outputs(expect_led(), expect_nums());
                                else
                                        check_outputs(steps[i].led, steps[i].nums);
                        end
                end
                $display("checks %0d, errors %0d", checks, errors);
                if (errors == 0)
                        $display("** PASS **");
                else
                        $display("** FAIL **");
                $finish;
        end

        // one tick window per step, or one per count for waits and presses
        initial begin
                longint budget;
                budget = 0;
                for (int i = 0; i < n_steps; i++)
                        budget += (steps[i].kind == k_wait || steps[i].kind == k_rand) ?
                                  int'(steps[i].arg) : 1;
                budget = budget * (tick_div + 40) * 4 + 1000;
                #(budget);
                $display("timeout: the run did not finish within %0d ns", budget);
                $display("** FAIL **");
                $finish;
        end

endmodule

//--- common/game_pkg.sv
package game_pkg;

        typedef logic [7:0]  scan_t;
        typedef logic [3:0]  digit_t;  // 15 is blank
        typedef logic [7:0]  bcd2_t;
        typedef logic [15:0] nums_t;   // leftmost digit in [15:12]
        typedef logic [15:0] led_t;

        typedef enum logic [1:0] {
                st_idle,
                st_setup,
                st_play,
                st_final
        } game_state_t;

        // keyboard set 2 codes
        parameter scan_t brk_prefix = 8'hf0;
        parameter scan_t ext_prefix = 8'he0;
        parameter scan_t space_code = 8'h29;

        parameter scan_t main_codes [0:9] = '{
                8'h45, 8'h16, 8'h1e, 8'h26, 8'h25, 8'h2e, 8'h36, 8'h3d, 8'h3e, 8'h46
        };
        parameter scan_t pad_codes [0:9] = '{
                8'h70, 8'h69, 8'h72, 8'h7a, 8'h6b, 8'h73, 8'h74, 8'h6c, 8'h75, 8'h7d
        };

        parameter led_t lfsr_taps    = 16'hb400;
        parameter led_t lfsr_seed    = 16'hace1;
        parameter led_t led_time_sel = 16'hff01;
        parameter led_t led_goal_sel = 16'h80ff;

        parameter bcd2_t time_default = 8'h30;
        parameter bcd2_t goal_default = 8'h10;

endpackage

//--- game/game_core.sv
`timescale 1ns/1ps

module game_core #(
        parameter int TICK_DIV = 50_000_000
) (
        input  logic             clk,
        input  logic             out_rst,
        input  logic             start,
        input  logic             key_hit,
        input  game_pkg::digit_t key_num,
        input  logic             space_hit,
        output game_pkg::led_t   led,
        output game_pkg::nums_t  nums
);

        localparam int tw = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
        localparam logic [tw-1:0] tick_last = tw'(TICK_DIV - 1);

        game_pkg::game_state_t state;
        game_pkg::game_state_t state_n;
        logic                  start_q;
        logic                  start_pulse;
        logic                  sel_goal;   // field being typed, 0 is time
        logic                  sel_goal_n;
        game_pkg::bcd2_t       time_fld;
        game_pkg::bcd2_t       time_fld_n;
        game_pkg::bcd2_t       goal_fld;
        game_pkg::bcd2_t       goal_fld_n;
        game_pkg::bcd2_t       remain;
        game_pkg::bcd2_t       remain_n;
        game_pkg::bcd2_t       score;
        game_pkg::bcd2_t       score_n;
        game_pkg::led_t        lfsr;
        game_pkg::led_t        lfsr_n;
        game_pkg::led_t        led_n;
        game_pkg::nums_t       nums_n;
        logic [tw-1:0]         tick_cnt;
        logic                  tick;

        function automatic game_pkg::bcd2_t bcd_inc(input game_pkg::bcd2_t v);
                if (v[3:0] != 4'd9)
                        return {v[7:4], v[3:0] + 4'd1};
                if (v[7:4] == 4'd9)
                        return 8'h00;
                return {v[7:4] + 4'd1, 4'd0};
        endfunction

        function automatic game_pkg::bcd2_t bcd_dec(input game_pkg::bcd2_t v);
                if (v[3:0] != 4'd0)
                        return {v[7:4], v[3:0] - 4'd1};
                return {v[7:4] - 4'd1, 4'd9};
        endfunction

        // galois lfsr shifting right
        function automatic game_pkg::led_t lfsr_step(input game_pkg::led_t v);
                if (v[0])
                        return (v >> 1) ^ game_pkg::lfsr_taps;
                return v >> 1;
        endfunction

        assign tick = (state == game_pkg::st_play) && (tick_cnt == tick_last);

        always_comb begin
                state_n    = state;
                sel_goal_n = sel_goal;
                time_fld_n = time_fld;
                goal_fld_n = goal_fld;
                remain_n   = remain;
                score_n    = score;
                lfsr_n     = lfsr;
                case (state)
                game_pkg::st_idle: begin
                        sel_goal_n = 1'b0;
                        time_fld_n = game_pkg::time_default;
                        goal_fld_n = game_pkg::goal_default;
                        if (start_pulse)
                                state_n = game_pkg::st_setup;
                end
                game_pkg::st_setup: begin
                        if (space_hit)
                                sel_goal_n = !sel_goal;
                        if (key_hit && sel_goal)
                                goal_fld_n = {goal_fld[3:0], key_num};
                        else if (key_hit)
                                time_fld_n = {time_fld[3:0], key_num};
                        if (start_pulse) begin
                                state_n  = game_pkg::st_play;
                                remain_n = time_fld;
                                score_n  = 8'h00;
                                lfsr_n   = game_pkg::lfsr_seed;
                        end
                end
                game_pkg::st_play: begin
                        if (score == goal_fld || remain == 8'h00)
                                state_n = game_pkg::st_final;
                        if (key_hit && lfsr[key_num])
                                score_n = bcd_inc(score);
                        if (tick && remain != 8'h00) begin
                                remain_n = bcd_dec(remain);
                                lfsr_n   = lfsr_step(lfsr);
                        end
                end
                default: begin
                        if (start_pulse)
                                state_n = game_pkg::st_idle;
                end
                endcase
        end

        // outputs follow the next state so they land with it
        always_comb begin
                case (state_n)
                game_pkg::st_idle: begin
                        led_n  = '0;
                        nums_n = '1;
                end
                game_pkg::st_setup: begin
                        led_n  = sel_goal_n ? game_pkg::led_goal_sel : game_pkg::led_time_sel;
                        nums_n = {time_fld_n, goal_fld_n};
                end
                game_pkg::st_play: begin
                        led_n  = lfsr_n;
                        nums_n = {remain_n, score_n};
                end
                default: begin
                        led_n  = '1;
                        nums_n = nums;  // frozen
                end
                endcase
        end

        always_ff @(posedge clk or posedge out_rst) begin
                if (out_rst) begin
                        state       <= game_pkg::st_idle;
                        start_q     <= 1'b0;
                        start_pulse <= 1'b0;
                        sel_goal    <= 1'b0;
                        time_fld    <= game_pkg::time_default;
                        goal_fld    <= game_pkg::goal_default;
                        remain      <= 8'h00;
                        score       <= 8'h00;
                        lfsr        <= game_pkg::lfsr_seed;
                        tick_cnt    <= '0;
                        led         <= '0;
                        nums        <= '1;
                end else begin
                        start_q     <= start;
                        start_pulse <= start && !start_q;  // rising edge
                        state       <= state_n;
                        sel_goal    <= sel_goal_n;
                        time_fld    <= time_fld_n;
                        goal_fld    <= goal_fld_n;
                        remain      <= remain_n;
                        score       <= score_n;
                        lfsr        <= lfsr_n;
                        led         <= led_n;
                        nums        <= nums_n;
                        if (state != game_pkg::st_play || tick)
                                tick_cnt <= '0;
                        else
                                tick_cnt <= tick_cnt + 1'b1;
                end
        end

        // idle, setup, play, final and round to idle, no skipping
        a_state_order: assert property (@(posedge clk) disable iff (out_rst)
                state != $past(state) |-> state == 2'($past(state) + 2'd1));

        a_score_bcd: assert property (@(posedge clk) disable iff (out_rst)
                score[3:0] <= 4'd9 && score[7:4] <= 4'd9);

endmodule

//--- src/key_decoder.sv
`timescale 1ns/1ps

module key_decoder (
        input  logic             clk,
        input  logic             out_rst,
        input  game_pkg::scan_t  scan_code,
        input  logic             scan_valid,
        output logic             key_hit,
        output game_pkg::digit_t key_num,
        output logic             space_hit
);

        logic             brk_seen;   // last byte was F0
        game_pkg::scan_t  held;       // key currently down, 0 if none
        logic             is_digit;
        game_pkg::digit_t dec_num;
        logic             is_prefix;
        logic             fresh_make;

        // main row and keypad both map to 0..9
        always_comb begin
                is_digit = 1'b0;
                dec_num  = 4'hf;
                for (int i = 0; i < 10; i++) begin
                        if (scan_code == game_pkg::main_codes[i] ||
                            scan_code == game_pkg::pad_codes[i]) begin
                                is_digit = 1'b1;
                                dec_num  = game_pkg::digit_t'(i);
                        end
                end
        end

        assign is_prefix  = (scan_code == game_pkg::brk_prefix) ||
                            (scan_code == game_pkg::ext_prefix);
        assign fresh_make = scan_valid && !is_prefix && !brk_seen && (scan_code != held);

        always_ff @(posedge clk or posedge out_rst) begin
                if (out_rst) begin
                        brk_seen  <= 1'b0;
                        held      <= '0;
                        key_hit   <= 1'b0;
                        space_hit <= 1'b0;
                end else begin
                        key_hit   <= fresh_make && is_digit;
                        space_hit <= fresh_make && (scan_code == game_pkg::space_code);
                        if (scan_valid) begin
                                if (scan_code == game_pkg::brk_prefix) begin
                                        brk_seen <= 1'b1;
                                end else if (scan_code != game_pkg::ext_prefix) begin
                                        brk_seen <= 1'b0;
                                        if (!brk_seen)
                                                held <= scan_code;
                                        else if (scan_code == held)
                                                held <= '0;  // released
                                end
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (fresh_make && is_digit)
                        key_num <= dec_num;
        end

        a_one_event: assert property (@(posedge clk) disable iff (out_rst)
                !(key_hit && space_hit));

endmodule

//--- src/seg_display.sv
`timescale 1ns/1ps

module seg_display #(
        parameter int SCAN_DIV = 100_000
) (
        input  logic            clk,
        input  logic            out_rst,
        input  game_pkg::nums_t nums,
        output logic [3:0]      digit,
        output logic [6:0]      display
);

        localparam int sw = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
        localparam logic [sw-1:0] scan_last = sw'(SCAN_DIV - 1);

        logic [sw-1:0]    refresh;
        logic             slot_end;
        logic [3:0]       digit_n;
        game_pkg::digit_t nib;
        logic [6:0]       seg;

        assign slot_end = (refresh == scan_last);

        // anode ring walks 3 -> 0, starts from all off
        assign digit_n = (digit == 4'b1111) ? 4'b0111 : {digit[0], digit[3:1]};

        always_comb begin
                case (digit_n)
                4'b0111: nib = nums[15:12];
                4'b1011: nib = nums[11:8];
                4'b1101: nib = nums[7:4];
                default: nib = nums[3:0];
                endcase
        end

        // active low, a in bit 0
        always_comb begin
                case (nib)
                4'd0:    seg = 7'h40;
                4'd1:    seg = 7'h79;
                4'd2:    seg = 7'h24;
                4'd3:    seg = 7'h30;
                4'd4:    seg = 7'h19;
                4'd5:    seg = 7'h12;
                4'd6:    seg = 7'h02;
                4'd7:    seg = 7'h78;
                4'd8:    seg = 7'h00;
                4'd9:    seg = 7'h10;
                default: seg = 7'h7f;  // blank
                endcase
        end

        always_ff @(posedge clk or posedge out_rst) begin
                if (out_rst) begin
                        refresh <= '0;
                        digit   <= 4'b1111;
                        display <= 7'h7f;
                end else if (slot_end) begin
                        refresh <= '0;
                        digit   <= digit_n;
                        display <= seg;
                end else begin
                        refresh <= refresh + 1'b1;
                end
        end

        // once scanning starts it never goes dark or doubles up
        a_one_anode: assert property (@(posedge clk) disable iff (out_rst)
                (digit != 4'b1111) |=> $onehot(~digit));

endmodule

//--- src/whack_top.sv
`timescale 1ns/1ps

module whack_top #(
        parameter int TICK_DIV = 50_000_000,
        parameter int SCAN_DIV = 100_000
) (
        input  logic            clk,
        input  logic            out_rst,
        input  game_pkg::scan_t scan_code,
        input  logic            scan_valid,
        input  logic            start,
        output game_pkg::led_t  led,
        output logic [3:0]      digit,
        output logic [6:0]      display
);

        logic             key_hit;
        game_pkg::digit_t key_num;
        logic             space_hit;
        game_pkg::nums_t  nums;

        key_decoder key_decoder_inst (
                .clk        (clk),
                .out_rst    (out_rst),
                .scan_code  (scan_code),
                .scan_valid (scan_valid),
                .key_hit    (key_hit),
                .key_num    (key_num),
                .space_hit  (space_hit)
        );

        game_core #(.TICK_DIV(TICK_DIV)) game_core_inst (
                .clk       (clk),
                .out_rst   (out_rst),
                .start     (start),
                .key_hit   (key_hit),
                .key_num   (key_num),
                .space_hit (space_hit),
                .led       (led),
                .nums      (nums)
        );

        seg_display #(.SCAN_DIV(SCAN_DIV)) seg_display_inst (
                .clk     (clk),
                .out_rst (out_rst),
                .nums    (nums),
                .digit   (digit),
                .display (display)
        );

endmodule

//--- verilog.f
common/game_pkg.sv
src/key_decoder.sv
game/game_core.sv
src/seg_display.sv
src/whack_top.sv
bench/tb_whack.sv
